//--- ciUnit_cfg.svh
`ifndef CIUNIT_CFG_SVH
`define CIUNIT_CFG_SVH

// custom instruction numbers as decoded from ciN
`define CI_EDGE_ID 8'd20
`define CI_GREY_ID 8'd21

// edge detection sub-commands, carried in the low byte of valueB
`define EDGE_SEL_LOAD    8'd1
`define EDGE_SEL_COMPUTE 8'd2

// grey level pixel width, shared by the window and the grey result
`define PIXEL_WIDTH 8

`endif

//--- ciPkg.sv
`default_nettype none

`include "ciUnit_cfg.svh"

package ciPkg;

    typedef logic [`PIXEL_WIDTH-1:0] pixelValue;

    // one instruction issue from the processor
    typedef struct packed {
        logic        start;
        logic [7:0]  ciN;
        logic [31:0] valueA;
        logic [31:0] valueB;
    } ciRequest;

    // one answer back to the processor
    typedef struct packed {
        logic        done;
        logic [31:0] result;
    } ciResponse;

    // valueB seen by a window load, only the select byte matters
    typedef struct packed {
        logic [23:0] unused;
        logic [7:0]  select;
    } edgeLoadWord;

    // valueB seen by a compute, carries the last pixel and the threshold
    typedef struct packed {
        logic [7:0] unused;
        pixelValue  threshold;
        pixelValue  pixel8;
        logic [7:0] select;
    } edgeComputeWord;

    typedef union packed {
        edgeLoadWord    loadWord;
        edgeComputeWord computeWord;
    } edgeOperandB;

    typedef struct packed {
        logic        flag;
        logic [19:0] zero;
        logic [10:0] magnitude;
    } edgeResult;

endpackage

`default_nettype wire

//--- sobelKernel.sv
`timescale 1ns/100ps
`default_nettype none

`include "ciUnit_cfg.svh"

module sobelKernel (
    input  wire [9*`PIXEL_WIDTH-1:0] window,
    input  wire [`PIXEL_WIDTH-1:0]   threshold,
    output ciPkg::edgeResult         edgeValue
);

    import ciPkg::*;

    // a 1-2-1 weighted sum of three pixels peaks at four times full scale
    localparam int sumWidth = `PIXEL_WIDTH + 2;

    pixelValue pixel [9];
    logic [sumWidth-1:0] leftSum;
    logic [sumWidth-1:0] rightSum;
    logic [sumWidth-1:0] topSum;
    logic [sumWidth-1:0] bottomSum;
    logic [sumWidth-1:0] gradX;
    logic [sumWidth-1:0] gradY;
    logic [sumWidth:0]   magnitude;

    // absolute difference without going through a signed value
    function automatic logic [sumWidth-1:0] absDiff(
        input logic [sumWidth-1:0] a,
        input logic [sumWidth-1:0] b
    );
        if (a >= b) begin
            return a - b;
        end
        return b - a;
    endfunction

    // pixel0 sits in the lowest byte, row-major order
    always_comb begin
        for (int i = 0; i < 9; i++) begin
            pixel[i] = window[i*`PIXEL_WIDTH +: `PIXEL_WIDTH];
        end
    end

    // column sums for the horizontal gradient
    assign leftSum = sumWidth'(pixel[0]) + (sumWidth'(pixel[3]) << 1)
                   + sumWidth'(pixel[6]);
    assign rightSum = sumWidth'(pixel[2]) + (sumWidth'(pixel[5]) << 1)
                    + sumWidth'(pixel[8]);

    // row sums for the vertical gradient
    assign topSum = sumWidth'(pixel[0]) + (sumWidth'(pixel[1]) << 1)
                  + sumWidth'(pixel[2]);
    assign bottomSum = sumWidth'(pixel[6]) + (sumWidth'(pixel[7]) << 1)
                     + sumWidth'(pixel[8]);

    assign gradX = absDiff(rightSum, leftSum);
    assign gradY = absDiff(bottomSum, topSum);

    // L1 norm, at most 2040
    assign magnitude = {1'b0, gradX} + {1'b0, gradY};

    always_comb begin
        edgeValue.flag      = magnitude > threshold;
        edgeValue.zero      = '0;
        edgeValue.magnitude = magnitude;
    end

endmodule

`default_nettype wire

//--- edgeDetection.sv
`timescale 1ns/100ps
`default_nettype none

`include "ciUnit_cfg.svh"

module edgeDetection (
    input  wire               clock,
    input  wire               reset,
    input  wire ciPkg::ciRequest request,
    output ciPkg::ciResponse  response
);

    import ciPkg::*;

    edgeOperandB operandB;
    logic isMine;
    logic doLoad;
    logic doCompute;
    logic computeDone;
    logic [9*`PIXEL_WIDTH-1:0] window;
    pixelValue threshold;
    edgeResult edgeValue;

    assign operandB = request.valueB;
    assign isMine   = request.start && (request.ciN == `CI_EDGE_ID);

    // the same valueB word is read as a load or as a compute
    assign doLoad    = isMine && (operandB.loadWord.select == `EDGE_SEL_LOAD);
    assign doCompute = isMine && (operandB.computeWord.select == `EDGE_SEL_COMPUTE);

    always_ff @(posedge clock) begin
        if (reset) begin
            window      <= '0;
            threshold   <= '0;
            computeDone <= 1'b0;
        end else begin
            computeDone <= doCompute;
            // valueA byte 0 lands in pixel0
            if (doLoad) begin
                window[4*`PIXEL_WIDTH-1:0] <= request.valueA;
            end
            // pixels 4 to 8 and the threshold arrive together
            if (doCompute) begin
                window[8*`PIXEL_WIDTH-1:4*`PIXEL_WIDTH] <= request.valueA;
                window[9*`PIXEL_WIDTH-1:8*`PIXEL_WIDTH] <= operandB.computeWord.pixel8;
                threshold <= operandB.computeWord.threshold;
            end
        end
    end

    // kernel sees the window one cycle after the compute strobe
    sobelKernel u_sobelKernel (
        .window   (window),
        .threshold(threshold),
        .edgeValue(edgeValue)
    );

    // load answers at once with a zero word and compute answers a cycle later
    always_comb begin
        response.done   = doLoad || computeDone;
        response.result = computeDone ? edgeValue : '0;
    end

    // the processor must wait for the compute answer before issuing again
    noStartWhilePending: assert property (
        @(posedge clock) disable iff (reset)
        computeDone |-> !isMine
    ) else $error("edge start issued while a compute answer is pending");

    loadComputeExclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(doLoad && computeDone)
    ) else $error("edge load and compute answered in the same cycle");

endmodule

`default_nettype wire

//--- greyConvert.sv
`timescale 1ns/100ps
`default_nettype none

`include "ciUnit_cfg.svh"

module greyConvert (
    input  wire ciPkg::ciRequest request,
    output ciPkg::ciResponse    response
);

    logic isMine;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic [15:0] weighted;
    logic [`PIXEL_WIDTH-1:0] grey;

    assign isMine = request.start && (request.ciN == `CI_GREY_ID);

    // RGB565 in valueA[15:0], each channel widened to 8 bits
    assign red   = {request.valueA[15:11], 3'b000};
    assign green = {request.valueA[10:5], 2'b00};
    assign blue  = {request.valueA[4:0], 3'b000};

    // weights sum to 256, so the total fits 16 bits
    assign weighted = 16'd77 * red + 16'd150 * green + 16'd29 * blue;
    assign grey     = weighted[15:8];

    // answer in the start cycle, nothing else on the bus otherwise
    always_comb begin
        response.done = isMine;
        if (isMine) begin
            response.result = {{(32-`PIXEL_WIDTH){1'b0}}, grey};
        end else begin
            response.result = '0;
        end
    end

endmodule

`default_nettype wire

//--- ciUnit.sv
`timescale 1ns/100ps
`default_nettype none

module ciUnit (
    input  wire                  clock,
    input  wire                  reset,
    input  wire ciPkg::ciRequest request,
    output ciPkg::ciResponse     response
);

    import ciPkg::*;

    ciResponse edgeResponse;
    ciResponse greyResponse;

    // both instructions see the same issue and decode ciN themselves
    edgeDetection u_edgeDetection (
        .clock   (clock),
        .reset   (reset),
        .request (request),
        .response(edgeResponse)
    );

    greyConvert u_greyConvert (
        .request (request),
        .response(greyResponse)
    );

    // idle blocks drive zeros, so an OR is enough to merge
    always_comb begin
        response.done   = edgeResponse.done | greyResponse.done;
        response.result = edgeResponse.result | greyResponse.result;
    end

    // a grey issue can't land on the cycle of a pending edge compute answer
    singleResponder: assert property (
        @(posedge clock) disable iff (reset)
        !(edgeResponse.done && greyResponse.done)
    ) else $error("edge and grey instructions answered in the same cycle");

endmodule

`default_nettype wire

//--- tbCiUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "ciUnit_cfg.svh"

module tbCiUnit;

    import ciPkg::*;

    localparam int edgeWindows   = 200;
    localparam int cornerWindows = 3;
    localparam int sweepSteps    = 256;
    localparam int greyRandom    = 300;
    localparam int greyFixed     = 5;
    localparam int mixedRounds   = 60;
    localparam int mixedMaxGrey  = 3;
    // worst case count of issued instructions over all tests
    localparam int maxIssues = 2 * (edgeWindows + cornerWindows) + 1 + sweepSteps
                             + greyRandom + greyFixed + mixedRounds * (2 + mixedMaxGrey);
    localparam int cycleLimit = 4 * maxIssues + 100;

    logic clock;
    logic reset;
    ciRequest request;
    ciResponse response;

    // reference copy of the edge window and threshold
    logic [`PIXEL_WIDTH-1:0] modelPixel [9];
    logic [`PIXEL_WIDTH-1:0] modelThreshold;

    bit expectDone;
    bit monitorOn;
    int passCount;
    int failCount;
    int failsAtStart;
    int cycleCount;

    ciUnit u_ciUnit (
        .clock   (clock),
        .reset   (reset),
        .request (request),
        .response(response)
    );

    always #4 clock = ~clock;

    task automatic reportWrong(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        failCount++;
    endtask

    task automatic reportProblem(input string what);
        $display("Error at %0d ns: %s", $time, what);
        failCount++;
    endtask

    task automatic finishTest(input string name);
        $display("test %s finished with %0d errors", name, failCount - failsAtStart);
        failsAtStart = failCount;
    endtask

    // L1 Sobel magnitude of the model window with the flag in bit 31
    function automatic logic [31:0] sobelExpected();
        int p [9];
        int gradX;
        int gradY;
        int magnitude;
        logic [31:0] word;
        for (int i = 0; i < 9; i++) begin
            p[i] = modelPixel[i];
        end
        gradX = (p[2] + 2 * p[5] + p[8]) - (p[0] + 2 * p[3] + p[6]);
        gradY = (p[6] + 2 * p[7] + p[8]) - (p[0] + 2 * p[1] + p[2]);
        if (gradX < 0) begin
            gradX = -gradX;
        end
        if (gradY < 0) begin
            gradY = -gradY;
        end
        magnitude  = gradX + gradY;
        word       = '0;
        word[10:0] = magnitude[10:0];
        word[31]   = (magnitude > int'(modelThreshold));
        return word;
    endfunction

    // channels widened to 8 bits and weighted 77, 150 and 29 over 256
    function automatic logic [31:0] greyExpected(input logic [15:0] rgb);
        int red;
        int green;
        int blue;
        red   = rgb[15:11] * 8;
        green = rgb[10:5] * 4;
        blue  = rgb[4:0] * 8;
        return (77 * red + 150 * green + 29 * blue) / 256;
    endfunction

    // issue one instruction and sample the answer at the falling edge of the cycle it is due
    task automatic issue(input logic [7:0] ciN, input logic [31:0] valueA,
                         input logic [31:0] valueB, input int latency,
                         output bit answered, output logic [31:0] result);
        ciRequest nextRequest;
        nextRequest.start  = 1'b1;
        nextRequest.ciN    = ciN;
        nextRequest.valueA = valueA;
        nextRequest.valueB = valueB;
        @(posedge clock);
        request <= nextRequest;
        for (int cycle = 0; cycle <= latency; cycle++) begin
            if (cycle > 0) begin
                @(posedge clock);
                request.start <= 1'b0;
            end
            expectDone = (cycle == latency);
            @(negedge clock);
        end
        answered = response.done;
        result   = response.result;
        @(posedge clock);
        request.start <= 1'b0;
        expectDone = 1'b0;
    endtask

    task automatic loadWindow(input logic [31:0] lowPixels);
        bit answered;
        logic [31:0] result;
        logic [31:0] operand;
        // only the select byte counts and the rest is noise
        operand      = $urandom();
        operand[7:0] = `EDGE_SEL_LOAD;
        issue(`CI_EDGE_ID, lowPixels, operand, 0, answered, result);
        for (int i = 0; i < 4; i++) begin
            modelPixel[i] = lowPixels[i*`PIXEL_WIDTH +: `PIXEL_WIDTH];
        end
        if (!answered) begin
            reportProblem("edge load gave no done in its start cycle");
        end else if (result !== 32'd0) begin
            reportWrong("edge load result", result, 32'd0);
        end else begin
            passCount++;
        end
    endtask

    task automatic computeWindow(input logic [31:0] highPixels,
                                 input logic [`PIXEL_WIDTH-1:0] lastPixel,
                                 input logic [`PIXEL_WIDTH-1:0] threshold,
                                 output logic [31:0] result);
        bit answered;
        logic [31:0] operand;
        logic [31:0] expected;
        // select, pixel 8 and threshold from the low byte up with noise in the top byte
        operand        = $urandom();
        operand[7:0]   = `EDGE_SEL_COMPUTE;
        operand[15:8]  = lastPixel;
        operand[23:16] = threshold;
        issue(`CI_EDGE_ID, highPixels, operand, 1, answered, result);
        for (int i = 4; i < 8; i++) begin
            modelPixel[i] = highPixels[(i-4)*`PIXEL_WIDTH +: `PIXEL_WIDTH];
        end
        modelPixel[8]  = lastPixel;
        modelThreshold = threshold;
        expected = sobelExpected();
        if (!answered) begin
            reportProblem("edge compute gave no done one cycle after its start");
        end else if (result !== expected) begin
            reportWrong("edge compute result", result, expected);
        end else begin
            passCount++;
        end
    endtask

    task automatic convertGrey(input logic [31:0] pixelWord);
        bit answered;
        logic [31:0] result;
        logic [31:0] expected;
        expected = greyExpected(pixelWord[15:0]);
        issue(`CI_GREY_ID, pixelWord, $urandom(), 0, answered, result);
        if (!answered) begin
            reportProblem("grey conversion gave no done in its start cycle");
        end else if (result !== expected) begin
            reportWrong("grey result", result, expected);
        end else begin
            passCount++;
        end
    endtask

    // done only when an answer is due and a zero result while idle
    always @(negedge clock) begin
        if (monitorOn) begin
            if (response.done && !expectDone) begin
                reportProblem("done raised in a cycle where no answer was due");
            end
            if (!response.done && response.result !== 32'd0) begin
                reportWrong("merged result without done", response.result, 32'd0);
            end
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] result;
        logic [31:0] expected;
        int transitions;
        int crossing;
        int greyCount;
        bit prevFlag;
        clock        = 1'b0;
        reset        = 1'b1;
        request      = '0;
        expectDone   = 1'b0;
        monitorOn    = 1'b0;
        passCount    = 0;
        failCount    = 0;
        failsAtStart = 0;
        void'($urandom(61275));
        for (int i = 0; i < 9; i++) begin
            modelPixel[i] = '0;
        end
        modelThreshold = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        // idle after reset
        repeat (8) begin
            @(negedge clock);
            if (response.done !== 1'b0 || response.result !== 32'd0) begin
                reportProblem("response active while start is low after reset");
            end else begin
                passCount++;
            end
        end
        finishTest("after reset");
        monitorOn = 1'b1;

        for (int i = 0; i < edgeWindows; i++) begin
            loadWindow($urandom());
            computeWindow($urandom(), 8'($urandom()), 8'($urandom()), result);
        end
        // flat black, flat white and a vertical step in the right column
        loadWindow(32'h0000_0000);
        computeWindow(32'h0000_0000, 8'h00, 8'd128, result);
        loadWindow(32'hFFFF_FFFF);
        computeWindow(32'hFFFF_FFFF, 8'hFF, 8'd128, result);
        loadWindow(32'h00FF_0000);
        computeWindow(32'h0000_FF00, 8'hFF, 8'd128, result);
        finishTest("edge windows");

        // gx 10 and gy 90, so the flag drops at threshold 100
        loadWindow(32'h281E_140A);
        transitions = 0;
        crossing    = -1;
        prevFlag    = 1'b0;
        for (int t = 0; t < sweepSteps; t++) begin
            computeWindow(32'h2846_3C32, 8'h14, 8'(t), result);
            if (t > 0 && result[31] != prevFlag) begin
                transitions++;
                crossing = t;
            end
            prevFlag = result[31];
        end
        expected = sobelExpected();
        if (transitions != 1 || crossing != int'(expected[10:0])) begin
            reportProblem("edge flag did not switch once at the window magnitude");
        end else begin
            passCount++;
        end
        finishTest("threshold sweep");

        // pure red, green, blue, black and white with noise in the upper half
        convertGrey({16'($urandom()), 16'hF800});
        convertGrey({16'($urandom()), 16'h07E0});
        convertGrey({16'($urandom()), 16'h001F});
        convertGrey({16'($urandom()), 16'h0000});
        convertGrey({16'($urandom()), 16'hFFFF});
        for (int i = 0; i < greyRandom; i++) begin
            convertGrey($urandom());
        end
        finishTest("grey conversion");

        for (int i = 0; i < mixedRounds; i++) begin
            loadWindow($urandom());
            greyCount = $urandom_range(mixedMaxGrey, 0);
            for (int g = 0; g < greyCount; g++) begin
                convertGrey($urandom());
            end
            computeWindow($urandom(), 8'($urandom()), 8'($urandom()), result);
        end
        finishTest("mixed traffic");

        $display("summary: %0d checks passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
ciPkg.sv
sobelKernel.sv
edgeDetection.sv
greyConvert.sv
ciUnit.sv
tbCiUnit.sv

//--- Makefile
# Verilator build, run and lint of the custom instruction unit
TOP = tbCiUnit

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

# the log decides the result, a crash without a pass line also counts as failure
run: build
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
